// File: common/dot_pkg.sv
package dot_pkg;

  // ==============================
  // Default sizes
  // ==============================

  // Element width in bits.
  localparam int DATA_W_DEF = 16;

  // Elements per vector.
  localparam int DEPTH_DEF = 8;

  // ==============================
  // Width helpers
  // ==============================

  // RAM address width is never below one bit.
  function automatic int addr_w(input int depth);
    return (depth > 1) ? $clog2(depth) : 1;
  endfunction

  // Element index width is wide enough to count up to depth.
  function automatic int idx_w(input int depth);
    return $clog2(depth) + 1;
  endfunction

  // Accumulator width.
  // Full product width plus growth for depth terms and one spare bit.
  function automatic int acc_w(input int data_w, input int depth);
    return 2 * data_w + $clog2(depth) + 1;
  endfunction

endpackage

// File: design/vector_ram.sv
`timescale 1ns/1ps

module vector_ram #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
) (
  input  logic                              clk,

  // Host write port.
  input  logic                              we_i,
  input  logic [dot_pkg::addr_w(DEPTH)-1:0] waddr_i,
  input  logic [DATA_W-1:0]                 wdata_i,

  // Loader read port.
  input  logic                              re_i,
  input  logic [dot_pkg::addr_w(DEPTH)-1:0] raddr_i,
  output logic [DATA_W-1:0]                 rdata_o
);

  // Storage array.
  logic [DATA_W-1:0] mem_q [DEPTH];

  // Registered read data.
  logic [DATA_W-1:0] rdata_q;

  // Write on the clock edge.
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Read data appears one edge after the request.
  // A same-cycle write to the read address returns the old word.
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_q <= mem_q[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: loader/vector_loader.sv
`timescale 1ns/1ps

module vector_loader #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
) (
  input  logic                              clk,
  input  logic                              rst_n,

  // Load strobe from the sequencer.
  input  logic                              load_i,

  // RAM read side.
  output logic                              ram_en_o,
  output logic [dot_pkg::addr_w(DEPTH)-1:0] ram_addr_o,
  input  logic [DATA_W-1:0]                 ram_dout_i,

  // Gathered vector with element 0 in the low bits.
  output logic [DEPTH*DATA_W-1:0]           vec_o,
  output logic                              loaded_o
);

  localparam int AW = dot_pkg::addr_w(DEPTH);
  localparam int IW = dot_pkg::idx_w(DEPTH);

  localparam logic [AW-1:0] LAST_ADDR = AW'(DEPTH - 1);
  localparam logic [IW-1:0] LAST_IDX  = IW'(DEPTH - 1);

  // ==============================
  // Declarations
  // ==============================

  logic                         rd_active_q;
  logic [AW-1:0]                rd_addr_q;
  logic                         rd_vld_q;
  logic [IW-1:0]                wr_idx_q;
  logic                         loaded_q;
  logic [DEPTH-1:0][DATA_W-1:0] slot_q;

  // ==============================
  // Address counter
  // ==============================

  // Walks addresses 0 to DEPTH-1, one per cycle.
  // A new load restarts from address 0.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_active_q <= 1'b0;
      rd_addr_q   <= '0;
    end else if (load_i) begin
      rd_active_q <= 1'b1;
      rd_addr_q   <= '0;
    end else if (rd_active_q) begin
      if (rd_addr_q == LAST_ADDR) begin
        rd_active_q <= 1'b0;
      end else begin
        rd_addr_q <= rd_addr_q + 1'b1;
      end
    end
  end

  assign ram_en_o   = rd_active_q;
  assign ram_addr_o = rd_addr_q;

  // Read-valid delayed by the RAM latency.
  // Dropped on a fresh load so no stale word lands in slot 0.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_active_q && !load_i;
    end
  end

  // ==============================
  // Gather
  // ==============================

  // Write index follows the returning words.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_idx_q <= '0;
      loaded_q <= 1'b0;
    end else begin
      loaded_q <= 1'b0;
      if (load_i) begin
        wr_idx_q <= '0;
      end else if (rd_vld_q) begin
        loaded_q <= (wr_idx_q == LAST_IDX);
        wr_idx_q <= wr_idx_q + 1'b1;
      end
    end
  end

  // Steer each word into its slot.
  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      slot_q[wr_idx_q] <= ram_dout_i;
    end
  end

  assign vec_o    = slot_q;
  assign loaded_o = loaded_q;

endmodule

// File: dot/dot_mac.sv
`timescale 1ns/1ps

module dot_mac #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            start_i,
  input  logic [DEPTH*DATA_W-1:0]                         a_vec_i,
  input  logic [DEPTH*DATA_W-1:0]                         b_vec_i,
  output logic signed [dot_pkg::acc_w(DATA_W, DEPTH)-1:0] sum_o,
  output logic                                            done_o
);

  localparam int IW = dot_pkg::idx_w(DEPTH);
  localparam int SW = dot_pkg::acc_w(DATA_W, DEPTH);
  localparam int PW = 2 * DATA_W;

  localparam logic [IW-1:0] LAST_IDX = IW'(DEPTH - 1);

  // Element pointer stage.
  logic                 run_q;
  logic [IW-1:0]        ptr_q;
  logic signed [DATA_W-1:0] a_word;
  logic signed [DATA_W-1:0] b_word;

  // Product stage.
  logic signed [PW-1:0] prod_q;
  logic                 prod_vld_q;
  logic                 prod_last_q;

  // Accumulate stage.
  logic signed [SW-1:0] acc_q;
  logic                 acc_last_q;
  logic                 done_q;

  // ==============================
  // Pointer
  // ==============================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
      ptr_q <= '0;
    end else if (start_i) begin
      run_q <= 1'b1;
      ptr_q <= '0;
    end else if (run_q) begin
      if (ptr_q == LAST_IDX) begin
        run_q <= 1'b0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // Pick the current pair.
  assign a_word = $signed(a_vec_i[ptr_q*DATA_W +: DATA_W]);
  assign b_word = $signed(b_vec_i[ptr_q*DATA_W +: DATA_W]);

  // ==============================
  // Multiply and accumulate
  // ==============================

  always_ff @(posedge clk) begin
    if (run_q) begin
      prod_q <= a_word * b_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_vld_q  <= 1'b0;
      prod_last_q <= 1'b0;
      acc_q       <= '0;
      acc_last_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      prod_vld_q  <= run_q;
      prod_last_q <= run_q && (ptr_q == LAST_IDX);
      acc_last_q  <= prod_last_q;
      // Sum is settled once the last flag leaves the adder.
      done_q      <= acc_last_q;
      if (start_i) begin
        acc_q <= '0;
      end else if (prod_vld_q) begin
        acc_q <= acc_q + SW'(prod_q);
      end
    end
  end

  assign sum_o  = acc_q;
  assign done_o = done_q;

endmodule

// File: design/dot_sequencer.sv
`timescale 1ns/1ps

module dot_sequencer #(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            start_i,
  input  logic                                            loaded_i,
  input  logic                                            mac_done_i,
  input  logic signed [dot_pkg::acc_w(DATA_W, DEPTH)-1:0] mac_sum_i,
  output logic                                            load_o,
  output logic                                            mac_start_o,
  output logic                                            busy_o,
  output logic                                            done_o,
  output logic signed [dot_pkg::acc_w(DATA_W, DEPTH)-1:0] result_o
);

  localparam int SW = dot_pkg::acc_w(DATA_W, DEPTH);

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_COMPUTE,
    S_FINISH
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic                 accept;
  logic signed [SW-1:0] result_q;

  // ==============================
  // FSM
  // ==============================

  // A new run may start from idle or in the done cycle.
  assign accept = start_i && ((state_q == S_IDLE) || (state_q == S_FINISH));

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (accept) state_d = S_LOAD;
      S_LOAD:    if (loaded_i) state_d = S_COMPUTE;
      S_COMPUTE: if (mac_done_i) state_d = S_FINISH;
      S_FINISH:  state_d = accept ? S_LOAD : S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Hold the sum until the next run finishes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_q <= '0;
    end else if ((state_q == S_COMPUTE) && mac_done_i) begin
      result_q <= mac_sum_i;
    end
  end

  // Strobes go out in the same cycle as their trigger.
  assign load_o      = accept;
  assign mac_start_o = (state_q == S_LOAD) && loaded_i;
  assign busy_o      = (state_q == S_LOAD) || (state_q == S_COMPUTE);
  assign done_o      = (state_q == S_FINISH);
  assign result_o    = result_q;

endmodule

// File: design/dot_top.sv
`timescale 1ns/1ps

module dot_top #(
  parameter int DATA_W = dot_pkg::DATA_W_DEF,
  parameter int DEPTH  = dot_pkg::DEPTH_DEF
) (
  input  logic                                            clk,
  input  logic                                            rst_n,

  // Host write port.
  input  logic                                            wr_en_i,
  input  logic                                            wr_sel_i,
  input  logic [dot_pkg::addr_w(DEPTH)-1:0]               wr_addr_i,
  input  logic [DATA_W-1:0]                               wr_data_i,

  // Run control and result.
  input  logic                                            start_i,
  output logic                                            busy_o,
  output logic                                            done_o,
  output logic signed [dot_pkg::acc_w(DATA_W, DEPTH)-1:0] result_o
);

  localparam int AW = dot_pkg::addr_w(DEPTH);
  localparam int SW = dot_pkg::acc_w(DATA_W, DEPTH);

  logic                     we_a;
  logic                     we_b;
  logic                     ram_en_a;
  logic                     ram_en_b;
  logic [AW-1:0]            ram_addr_a;
  logic [AW-1:0]            ram_addr_b;
  logic [DATA_W-1:0]        ram_dout_a;
  logic [DATA_W-1:0]        ram_dout_b;
  logic [DEPTH*DATA_W-1:0]  vec_a;
  logic [DEPTH*DATA_W-1:0]  vec_b;
  logic                     load;
  logic                     loaded_a;
  logic                     mac_start;
  logic                     mac_done;
  logic signed [SW-1:0]     mac_sum;

  // Select 0 writes vector a, select 1 writes vector b.
  assign we_a = wr_en_i && !wr_sel_i;
  assign we_b = wr_en_i && wr_sel_i;

  // ==============================
  // Vector storage
  // ==============================

  vector_ram #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_ram_a (
    .clk(clk), .we_i(we_a), .waddr_i(wr_addr_i), .wdata_i(wr_data_i),
    .re_i(ram_en_a), .raddr_i(ram_addr_a), .rdata_o(ram_dout_a)
  );

  vector_ram #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_ram_b (
    .clk(clk), .we_i(we_b), .waddr_i(wr_addr_i), .wdata_i(wr_data_i),
    .re_i(ram_en_b), .raddr_i(ram_addr_b), .rdata_o(ram_dout_b)
  );

  // ==============================
  // Loaders
  // ==============================

  vector_loader #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_load_a (
    .clk(clk), .rst_n(rst_n), .load_i(load),
    .ram_en_o(ram_en_a), .ram_addr_o(ram_addr_a), .ram_dout_i(ram_dout_a),
    .vec_o(vec_a), .loaded_o(loaded_a)
  );

  // Same timing as loader a, so its loaded strobe is left open.
  vector_loader #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_load_b (
    .clk(clk), .rst_n(rst_n), .load_i(load),
    .ram_en_o(ram_en_b), .ram_addr_o(ram_addr_b), .ram_dout_i(ram_dout_b),
    .vec_o(vec_b), .loaded_o()
  );

  // ==============================
  // Datapath and control
  // ==============================

  dot_mac #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_mac (
    .clk(clk), .rst_n(rst_n), .start_i(mac_start),
    .a_vec_i(vec_a), .b_vec_i(vec_b), .sum_o(mac_sum), .done_o(mac_done)
  );

  dot_sequencer #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_seq (
    .clk(clk), .rst_n(rst_n), .start_i(start_i), .loaded_i(loaded_a),
    .mac_done_i(mac_done), .mac_sum_i(mac_sum), .load_o(load),
    .mac_start_o(mac_start), .busy_o(busy_o), .done_o(done_o),
    .result_o(result_o)
  );

endmodule

// File: test/tb_dot_top.sv
`timescale 1ns/1ps

module tb_dot_top;

  localparam int DATA_W   = dot_pkg::DATA_W_DEF;
  localparam int DEPTH    = dot_pkg::DEPTH_DEF;
  localparam int AW       = dot_pkg::addr_w(DEPTH);
  localparam int SW       = dot_pkg::acc_w(DATA_W, DEPTH);
  localparam int LATENCY  = 2 * DEPTH + 5;
  localparam int MAX_WAIT = 100;

  localparam logic signed [DATA_W-1:0] MAX_VAL = {1'b0, {(DATA_W-1){1'b1}}};
  localparam logic signed [DATA_W-1:0] MIN_VAL = {1'b1, {(DATA_W-1){1'b0}}};

  logic                 clk;
  logic                 rst_n;
  logic                 wr_en_i;
  logic                 wr_sel_i;
  logic [AW-1:0]        wr_addr_i;
  logic [DATA_W-1:0]    wr_data_i;
  logic                 start_i;
  logic                 busy_o;
  logic                 done_o;
  logic signed [SW-1:0] result_o;

  // Model copies of both vectors.
  logic signed [DATA_W-1:0] a_model [DEPTH];
  logic signed [DATA_W-1:0] b_model [DEPTH];

  // Sum the DUT should be holding between runs.
  longint held_sum;

  int errors;

  dot_top u_dot_top (
    .clk(clk), .rst_n(rst_n), .wr_en_i(wr_en_i), .wr_sel_i(wr_sel_i),
    .wr_addr_i(wr_addr_i), .wr_data_i(wr_data_i), .start_i(start_i),
    .busy_o(busy_o), .done_o(done_o), .result_o(result_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ==============================
  // Model and helpers
  // ==============================

  // Signed dot product of the model vectors.
  function automatic longint model_sum();
    longint sum;
    sum = 0;
    for (int i = 0; i < DEPTH; i++) begin
      sum += longint'(a_model[i]) * longint'(b_model[i]);
    end
    return sum;
  endfunction

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic fill_random();
    for (int i = 0; i < DEPTH; i++) begin
      a_model[i] = DATA_W'($urandom());
      b_model[i] = DATA_W'($urandom());
    end
  endtask

  // One host write held for one clock.
  task automatic write_word(input logic sel, input int addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    wr_en_i   = 1'b1;
    wr_sel_i  = sel;
    wr_addr_i = AW'(addr);
    wr_data_i = data;
  endtask

  task automatic write_vectors();
    for (int i = 0; i < DEPTH; i++) begin
      write_word(1'b0, i, a_model[i]);
      write_word(1'b1, i, b_model[i]);
    end
  endtask

  // Start a run and optionally pulse start again at cycle extra_start_at.
  task automatic run_and_check(input string name, input int extra_start_at);
    longint expected;
    int     cycles;
    bit     seen_done;
    expected  = model_sum();
    cycles    = 0;
    seen_done = 1'b0;
    @(negedge clk);
    // The previous sum is still held when the next run starts.
    if (result_o !== SW'(held_sum)) begin
      report_error($sformatf("%s result %0d before start, expected %0d",
                             name, result_o, held_sum));
    end
    wr_en_i = 1'b0;
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
    // Cycle 0 is the one right after start is taken.
    while (!seen_done && cycles < MAX_WAIT) begin
      if (done_o) begin
        seen_done = 1'b1;
      end else begin
        if (busy_o !== 1'b1) begin
          report_error($sformatf("%s busy_o low at cycle %0d", name, cycles));
        end
        start_i = (cycles == extra_start_at);
        @(negedge clk);
        cycles++;
      end
    end
    start_i = 1'b0;
    if (!seen_done) begin
      $display("%s: done never arrived within %0d cycles", name, MAX_WAIT);
      errors++;
    end else begin
      if (cycles != LATENCY) begin
        report_error($sformatf("%s done after %0d cycles, expected %0d",
                               name, cycles, LATENCY));
      end
      if (result_o !== SW'(expected)) begin
        report_error($sformatf("%s result %0d, expected %0d", name, result_o, expected));
      end
      if (busy_o !== 1'b0) begin
        report_error($sformatf("%s busy_o high in done cycle", name));
      end
      held_sum = expected;
      // Result must hold and no second done may follow.
      repeat (LATENCY + 4) begin
        @(negedge clk);
        if (done_o !== 1'b0) begin
          report_error($sformatf("%s extra done pulse", name));
        end
        if (busy_o !== 1'b0) begin
          report_error($sformatf("%s busy_o high while idle", name));
        end
        if (result_o !== SW'(expected)) begin
          report_error($sformatf("%s result changed to %0d, expected %0d",
                                 name, result_o, expected));
        end
      end
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial begin
    void'($urandom(32'h699a));
    errors    = 0;
    held_sum  = 0;
    rst_n     = 1'b0;
    wr_en_i   = 1'b0;
    wr_sel_i  = 1'b0;
    wr_addr_i = '0;
    wr_data_i = '0;
    start_i   = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset state.
    if (busy_o !== 1'b0 || done_o !== 1'b0 || result_o !== '0) begin
      report_error("outputs not idle after reset");
    end

    // Random full-range vectors.
    for (int run = 0; run < 20; run++) begin
      fill_random();
      write_vectors();
      run_and_check($sformatf("random run %0d", run), -1);
    end

    // Extreme values give the largest magnitude sums.
    for (int i = 0; i < DEPTH; i++) begin
      a_model[i] = MIN_VAL;
      b_model[i] = MIN_VAL;
    end
    write_vectors();
    run_and_check("all minimum", -1);

    for (int i = 0; i < DEPTH; i++) begin
      a_model[i] = MAX_VAL;
    end
    write_vectors();
    run_and_check("maximum times minimum", -1);

    for (int i = 0; i < DEPTH; i++) begin
      a_model[i] = (i % 2) ? MAX_VAL : MIN_VAL;
      b_model[i] = (i % 2) ? MAX_VAL : MIN_VAL;
    end
    write_vectors();
    run_and_check("alternating extremes", -1);

    // Second start in the middle of a run.
    fill_random();
    write_vectors();
    run_and_check("start while busy", 5);

    // Only one element of b changes.
    b_model[3] = ~b_model[3];
    write_word(1'b1, 3, b_model[3]);
    run_and_check("partial rewrite", -1);

    $display("Run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dot_engine.f
common/dot_pkg.sv
design/vector_ram.sv
loader/vector_loader.sv
dot/dot_mac.sv
design/dot_sequencer.sv
design/dot_top.sv
test/tb_dot_top.sv
